// ==== logic/stream_switch_pkg.sv ====
/* shared widths, serial timing and bus types of the stream switch.
   the scheduler rotation is built for exactly eight streams of one byte each. */
`default_nettype none

package stream_switch_pkg;

	//////////////////////////////////////////////////
	// sizes and timing
	//////////////////////////////////////////////////

	localparam int NUM_STREAMS  = 8;  // number of data streams sharing the link.
	localparam int STREAM_IDX_W = 3;  // enough to number every stream.
	localparam int SLOT_W       = 10; // width of the slice length and the slice timer.

	// the transmitter and the receiver model in the testbench both run from this.
	localparam int CLKS_PER_BIT = 4;

	// a frame is one start bit, eight data bits and one stop bit.
	localparam int FRAME_BITS = 10;
	localparam int BIT_CNT_W  = $clog2(FRAME_BITS); // counts the bits of one frame.

	// the baud counter still needs one bit when a bit lasts a single cycle.
	localparam int BAUD_CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	//////////////////////////////////////////////////
	// bus types
	//////////////////////////////////////////////////

	// selection driven by the scheduler.
	typedef struct packed {
		logic                    valid;   // a source is granted right now.
		logic                    at_mode; // the command channel holds the link.
		logic [STREAM_IDX_W-1:0] index;   // granted stream, only when at_mode is clear.
	} stream_sel_t;

	// static setup for one sending session.
	typedef struct packed {
		logic                   want_at;     // pass the command byte through instead.
		logic [NUM_STREAMS-1:0] stream_mask; // bit n enables stream n.
		logic [SLOT_W-1:0]      slot_len;    // a slice lasts slot_len+1 cycles.
	} sched_cfg_t;

	// every stream byte side by side, stream n in bits 8n+7 down to 8n.
	typedef logic [NUM_STREAMS-1:0][7:0] stream_bytes_t;

endpackage

`default_nettype wire

// ==== logic/stream_scheduler.sv ====
/* round-robin slice scheduler with a command mode override.
   cfg_i must stay stable while sending_i is high; an all-zero mask never grants. */
`timescale 1ns/10ps
`default_nettype none

module stream_scheduler (
	input  wire                            clock,
	input  wire                            resetn,
	input  wire                            sending_i, // session request, held as a level.
	input  wire stream_switch_pkg::sched_cfg_t cfg_i,
	output stream_switch_pkg::stream_sel_t     sel_o
);
	import stream_switch_pkg::*;

	// command mode sits apart from the walk states at all ones.
	typedef enum logic [2:0] {
		ST_IDLE    = 3'b000,
		ST_LOAD    = 3'b001,
		ST_FIND    = 3'b010,
		ST_RUN     = 3'b011,
		ST_COMMAND = 3'b111
	} state_t;

	state_t                  state_q;    // current state.
	state_t                  state_d;    // next state.
	logic [NUM_STREAMS-1:0]  rot_q;      // rotating copy of the mask, bit 0 is stream index_q.
	logic [STREAM_IDX_W-1:0] index_q;    // stream number lined up with rot_q[0].
	logic [SLOT_W-1:0]       timer_q;    // cycles spent in the current slice.
	logic                    slice_done; // last cycle of a slice.
	logic                    advance;    // step rotator and index to the next stream.

	//////////////////////////////////////////////////
	// rotation control
	//////////////////////////////////////////////////

	// the timer starts at zero so a slice covers slot_len+1 cycles.
	assign slice_done = (state_q == ST_RUN) && (timer_q == cfg_i.slot_len);

	// skip a disabled stream while searching, or move on once a slice ends.
	assign advance = ((state_q == ST_FIND) && !rot_q[0]) || slice_done;

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q; // stay put unless a case below says otherwise.
		case (state_q)
			ST_IDLE:
			begin
				if (sending_i)
					state_d = cfg_i.want_at ? ST_COMMAND : ST_LOAD;
			end
			ST_COMMAND:
			begin
				if (!sending_i)
					state_d = ST_IDLE; // the command channel is held for the whole request.
			end
			ST_LOAD:
			begin
				state_d = ST_FIND; // the mask is copied in exactly one cycle.
			end
			ST_FIND:
			begin
				if (!sending_i)
					state_d = ST_IDLE;
				else if (rot_q[0])
					state_d = ST_RUN; // found an enabled stream.
			end
			ST_RUN:
			begin
				// sending_i is only looked at again once the slice is over.
				if (slice_done)
					state_d = ST_FIND;
			end
			default:
			begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	//////////////////////////////////////////////////
	// counters
	//////////////////////////////////////////////////

	// slice timer. Cleared on every search cycle, counts only while a stream runs.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			timer_q <= '0;
		else if (state_q == ST_FIND)
			timer_q <= '0;
		else if (state_q == ST_RUN)
			timer_q <= timer_q + SLOT_W'(1);
	end

	// rotator and index move together so rot_q[0] always belongs to index_q.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			rot_q   <= '0;
			index_q <= '0;
		end
		else if (state_q == ST_IDLE)
		begin
			rot_q   <= '0; // every session starts again from stream 0.
			index_q <= '0;
		end
		else if (state_q == ST_LOAD)
			rot_q <= cfg_i.stream_mask;
		else if (advance)
		begin
			rot_q   <= {rot_q[0], rot_q[NUM_STREAMS-1:1]}; // right turn, 7 wraps to 0.
			index_q <= index_q + STREAM_IDX_W'(1);        // wraps with the rotator.
		end
	end

	//////////////////////////////////////////////////
	// selection output
	//////////////////////////////////////////////////

	always_comb
	begin
		sel_o = '0; // nothing granted in idle, load and find.
		case (state_q)
			ST_COMMAND:
			begin
				sel_o.valid   = 1'b1;
				sel_o.at_mode = 1'b1;
			end
			ST_RUN:
			begin
				sel_o.valid = 1'b1;
				sel_o.index = index_q;
			end
			default:
			begin
				sel_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/frame_loader.sv ====
/* picks the byte of the granted source and starts a frame whenever the transmitter is free.
   source bytes are sampled once per frame and never queued. */
`timescale 1ns/10ps
`default_nettype none

module frame_loader (
	input  wire                               clock,
	input  wire                               resetn,
	input  wire stream_switch_pkg::stream_sel_t   sel_i,
	input  wire stream_switch_pkg::stream_bytes_t streams_i,
	input  wire [7:0]                         at_byte_i,  // command byte, passed through as is.
	input  wire                               tx_busy_i,  // high while a frame is on the line.
	output logic [7:0]                        tx_byte_o,  // byte handed to the transmitter.
	output logic                              tx_start_o  // one cycle pulse, starts a frame.
);

	logic [7:0] src_byte;   // byte of whatever source is granted now.
	logic       start_cond; // a frame may begin with the next edge.

	//////////////////////////////////////////////////
	// source selection
	//////////////////////////////////////////////////

	// the command channel takes priority over the stream index.
	always_comb
	begin
		if (sel_i.at_mode)
			src_byte = at_byte_i;
		else
			src_byte = streams_i[sel_i.index];
	end

	// busy only rises on the edge after the pulse, so the last pulse
	// itself has to block a second start in the following cycle.
	assign start_cond = sel_i.valid && !tx_busy_i && !tx_start_o;

	//////////////////////////////////////////////////
	// start pulse and holding register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			tx_start_o <= 1'b0;
		else
			tx_start_o <= start_cond; // never high twice in a row.
	end

	// the byte is captured on the same edge that raises the pulse.
	always_ff @(posedge clock)
	begin
		if (start_cond)
			tx_byte_o <= src_byte;
	end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
/* 8N1 serial transmitter with a fixed divider of CLKS_PER_BIT cycles per bit.
   start_i is ignored while busy_o is high; the line idles high. */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  wire       clock,
	input  wire       resetn,
	input  wire       start_i, // single cycle request, byte_i valid with it.
	input  wire [7:0] byte_i,
	output logic      busy_o,  // level, high from the start bit to the end of the stop bit.
	output logic      tx_o     // serial line.
);
	import stream_switch_pkg::*;

	logic [BAUD_CNT_W-1:0] baud_q;  // cycles spent in the current bit.
	logic [BIT_CNT_W-1:0]  bit_q;   // bit of the frame being sent.
	logic [FRAME_BITS-1:0] shift_q; // frame being sent, bit 0 is on the line.
	logic                  busy_q;
	logic                  bit_end; // last cycle of the current bit.

	assign bit_end = busy_q && (baud_q == BAUD_CNT_W'(CLKS_PER_BIT - 1));

	//////////////////////////////////////////////////
	// serializer
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			busy_q  <= 1'b0;
			baud_q  <= '0;
			bit_q   <= '0;
			shift_q <= '1; // all ones keeps the line at the idle level.
		end
		else if (!busy_q)
		begin
			if (start_i)
			begin
				busy_q  <= 1'b1;
				baud_q  <= '0;
				bit_q   <= '0;
				shift_q <= {1'b1, byte_i, 1'b0}; // stop, data lsb first, start.
			end
		end
		else
		begin
			// divider runs for every bit of the frame.
			if (bit_end)
				baud_q <= '0;
			else
				baud_q <= baud_q + BAUD_CNT_W'(1);

			if (bit_end)
			begin
				shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]}; // ones fill in behind.
				if (bit_q == BIT_CNT_W'(FRAME_BITS - 1))
				begin
					busy_q <= 1'b0; // the stop bit has been held for a full bit time.
					bit_q  <= '0;
				end
				else
					bit_q <= bit_q + BIT_CNT_W'(1);
			end
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	assign busy_o = busy_q;
	assign tx_o   = shift_q[0]; // straight from a flop, so the line has no glitches.

endmodule

`default_nettype wire

// ==== logic/stream_switch_top.sv ====
/* output side of the sensor link: scheduler, frame loader and serial transmitter.
   a frame starts two cycles after a valid selection meets an idle transmitter. */
`timescale 1ns/10ps
`default_nettype none

module stream_switch_top (
	input  wire                               clock,
	input  wire                               resetn,
	input  wire                               sending_i,
	input  wire stream_switch_pkg::sched_cfg_t    cfg_i,
	input  wire stream_switch_pkg::stream_bytes_t streams_i,
	input  wire [7:0]                         at_byte_i,
	output stream_switch_pkg::stream_sel_t        select_o,
	output logic                              tx_o
);
	import stream_switch_pkg::*;

	stream_sel_t sel;      // current grant, also visible at the top.
	logic [7:0]  tx_byte;  // latched frame byte.
	logic        tx_start; // one cycle frame request.
	logic        tx_busy;  // transmitter is sending a frame.

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	stream_scheduler i_stream_scheduler (
		.clock     (clock),
		.resetn    (resetn),
		.sending_i (sending_i),
		.cfg_i     (cfg_i),
		.sel_o     (sel)
	);

	frame_loader i_frame_loader (
		.clock      (clock),
		.resetn     (resetn),
		.sel_i      (sel),
		.streams_i  (streams_i),
		.at_byte_i  (at_byte_i),
		.tx_busy_i  (tx_busy), // the only back-pressure in the design.
		.tx_byte_o  (tx_byte),
		.tx_start_o (tx_start)
	);

	uart_tx i_uart_tx (
		.clock   (clock),
		.resetn  (resetn),
		.start_i (tx_start),
		.byte_i  (tx_byte),
		.busy_o  (tx_busy),
		.tx_o    (tx_o)
	);

	assign select_o = sel;

endmodule

`default_nettype wire

// ==== verification/stream_switch_checker.sv ====
/* concurrent checks on the stream scheduler and the frame loader.
   inputs that one of the two targets lacks are tied off at its bind. */
`timescale 1ns/10ps
`default_nettype none

module stream_switch_checker (
	input wire                                 clock,
	input wire                                 resetn,
	input wire stream_switch_pkg::stream_sel_t sel_i,        // selection seen by the target.
	input wire                                 start_i,      // frame start pulse.
	input wire                                 run_or_find_i // scheduler walks the mask.
);

	int unsigned failures = 0; // failed assertions, summed up by the testbench.
	logic        stream_grant; // a data stream holds the link.

	assign stream_grant = sel_i.valid && !sel_i.at_mode;

	//////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////

	// busy arrives one edge late, so the loader must guard against a second pulse.
	a_single_start: assert property (@(posedge clock) disable iff (!resetn)
		start_i |=> !start_i)
	else
	begin
		failures++;
		$error("tx_start was high in two consecutive cycles.");
	end

	// the command channel only exists outside of the mask walk.
	a_command_apart: assert property (@(posedge clock) disable iff (!resetn)
		(sel_i.valid && sel_i.at_mode) |-> !run_or_find_i)
	else
	begin
		failures++;
		$error("command grant overlapped the find or run state.");
	end

	// a slice always ends through a find cycle, never by a direct index change.
	a_index_hold: assert property (@(posedge clock) disable iff (!resetn)
		(stream_grant && $past(stream_grant)) |-> (sel_i.index == $past(sel_i.index)))
	else
	begin
		failures++;
		$error("stream index changed during a grant.");
	end

endmodule

bind stream_scheduler stream_switch_checker i_sched_checker (
	.clock         (clock),
	.resetn        (resetn),
	.sel_i         (sel_o),
	.start_i       (1'b0),
	.run_or_find_i ((state_q == ST_FIND) || (state_q == ST_RUN))
);

bind frame_loader stream_switch_checker i_loader_checker (
	.clock         (clock),
	.resetn        (resetn),
	.sel_i         (sel_i),
	.start_i       (tx_start_o),
	.run_or_find_i (1'b0)
);

`default_nettype wire

// ==== verification/tb_stream_switch.sv ====
/* file-driven testbench for the stream switch. the vectors are read from
   verification/stream_switch_tests.txt and frames are rebuilt by a receiver
   that samples tx_o mid-bit, one bit every CLKS_PER_BIT cycles. */
`timescale 1ns/10ps
`default_nettype none

module tb_stream_switch;
	import stream_switch_pkg::*;

	localparam int MAX_TESTS   = 32;
	localparam int FIELDS      = 6;                            // words per test line.
	localparam int DRAIN_ALLOW = 2 * FRAME_BITS * CLKS_PER_BIT; // end of a test left for the last frame.
	localparam int QUIET_NEED  = 4;                            // idle cycles that close a test.

	logic          clock;
	logic          resetn;
	logic          sending;
	sched_cfg_t    cfg;
	stream_bytes_t streams;
	logic [7:0]    at_byte;
	stream_sel_t   select;
	logic          tx;

	logic [15:0]   test_mem [0:MAX_TESTS*FIELDS-1];
	int            num_tests;
	int            run_total;
	int            cycle_count;
	int            cycle_limit;
	int            error_count;
	int            frame_count;
	int            grant_count;
	int            assert_count;
	logic          cur_want_at;   // setup of the test that runs now.
	logic [7:0]    cur_mask;
	logic [SLOT_W-1:0] cur_slot;
	logic [STREAM_IDX_W-1:0] expect_idx; // next grant predicted from the mask.
	int            frames_in_test;
	int            grants_in_test;
	stream_sel_t   sel_hist [0:2]; // selection of this and the two earlier cycles.
	stream_sel_t   prev_sel;
	logic          prev_sending;
	int            grant_len;
	logic          rx_active;
	logic          rx_expect_ok;
	int            rx_count;
	logic [7:0]    rx_data;
	logic [7:0]    rx_expect;
	int            quiet_cycles;

	stream_switch_top i_stream_switch_top (
		.clock     (clock),
		.resetn    (resetn),
		.sending_i (sending),
		.cfg_i     (cfg),
		.streams_i (streams),
		.at_byte_i (at_byte),
		.select_o  (select),
		.tx_o      (tx)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock; // 40 ns period.
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout, the tests did not finish within %0d cycles.", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// reference model and monitors
	//////////////////////////////////////////////////

	// first enabled stream above the given one, wrapping from 7 to 0.
	function automatic logic [STREAM_IDX_W-1:0] next_stream(input logic [NUM_STREAMS-1:0] mask,
		input logic [STREAM_IDX_W-1:0] after);
		logic [STREAM_IDX_W-1:0] idx;
		idx = after;
		for (int n = 0; n < NUM_STREAMS; n++)
		begin
			idx = idx + STREAM_IDX_W'(1);
			if (mask[idx])
				return idx;
		end
		return after; // empty mask, never used for a grant.
	endfunction

	task track_grants;
		if (select.valid && !select.at_mode)
		begin
			if (!(prev_sel.valid && !prev_sel.at_mode))
			begin
				if (cur_want_at || cur_mask == '0)
				begin
					$display("stream %0d was granted although no stream could be.", select.index);
					error_count++;
				end
				else if (select.index !== expect_idx)
				begin
					$display("FAIL select_o.index: expected %h got %h", expect_idx, select.index);
					error_count++;
				end
				grant_len = 1; // a new slice begins.
				grants_in_test++;
				grant_count++;
			end
			else
				grant_len++;
		end
		else if (prev_sel.valid && !prev_sel.at_mode)
		begin
			if (grant_len != int'(cur_slot) + 1)
			begin
				$display("FAIL select_o.valid cycles: expected %h got %h", int'(cur_slot) + 1,
					grant_len);
				error_count++;
			end
			expect_idx = next_stream(cur_mask, prev_sel.index);
		end
	endtask

	task check_mode;
		// the command grant follows sending with one cycle of delay.
		if (cur_want_at && sending && prev_sending)
		begin
			if (!(select.valid && select.at_mode))
			begin
				$display("FAIL select_o.valid/at_mode: expected 3 got %h",
					{select.valid, select.at_mode});
				error_count++;
			end
		end
		else if (!cur_want_at && select.at_mode)
		begin
			$display("the command channel was granted in stream mode.");
			error_count++;
		end
	endtask

	task receive_serial;
		int offset;
		if (!rx_active)
		begin
			if (tx == 1'b0)
			begin
				rx_active    = 1'b1; // first sample inside the start bit.
				rx_count     = 0;
				rx_data      = '0;
				rx_expect_ok = sel_hist[2].valid;
				if (!sel_hist[2].valid)
				begin
					$display("a frame started without a granted source two cycles before.");
					error_count++;
					rx_expect = '0;
				end
				else if (sel_hist[2].at_mode)
					rx_expect = at_byte;
				else
					rx_expect = streams[sel_hist[2].index];
			end
		end
		else
		begin
			rx_count++;
			offset = rx_count - CLKS_PER_BIT / 2;
			if (offset == 0 && tx !== 1'b0)
			begin
				$display("the start bit did not last until mid-bit.");
				error_count++;
			end
			else if (offset > 0 && offset < 9 * CLKS_PER_BIT && offset % CLKS_PER_BIT == 0)
				rx_data = {tx, rx_data[7:1]}; // data arrives lsb first.
			else if (offset == 9 * CLKS_PER_BIT)
			begin
				if (tx !== 1'b1)
				begin
					$display("FAIL tx_o stop bit: expected 1 got %h", tx);
					error_count++;
				end
				if (rx_expect_ok && rx_data !== rx_expect)
				begin
					$display("FAIL tx_o byte: expected %h got %h", rx_expect, rx_data);
					error_count++;
				end
				rx_active = 1'b0;
				frame_count++;
				frames_in_test++;
			end
		end
	endtask

	// outputs are sampled on the falling edge, half a cycle away from any change.
	always @(negedge clock)
	begin
		sel_hist[2] = sel_hist[1];
		sel_hist[1] = sel_hist[0];
		sel_hist[0] = select;
		if (resetn)
		begin
			track_grants();
			check_mode();
			receive_serial();
		end
		if (!select.valid && !rx_active && tx)
			quiet_cycles++;
		else
			quiet_cycles = 0;
		prev_sel     = select;
		prev_sending = sending;
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic run_test(input int t);
		int            base;
		int            hold;
		logic [15:0]   data;
		stream_bytes_t fill;
		base = t * FIELDS;
		data = test_mem[base + 4];
		for (int n = 0; n < NUM_STREAMS; n++)
		begin
			if (data == '0)
				fill[n] = 8'($urandom);
			else
				fill[n] = data[7:0] ^ 8'(n * 37); // differs for every stream number.
		end
		hold = int'(test_mem[base + 5]) - DRAIN_ALLOW;
		if (hold < 1)
		begin
			$display("test %0d is too short to leave room for its last frame.", t);
			error_count++;
			hold = 1;
		end
		@(posedge clock);
		cur_want_at    = test_mem[base][0];
		cur_mask       = test_mem[base + 1][7:0];
		cur_slot       = test_mem[base + 2][SLOT_W-1:0];
		expect_idx     = next_stream(cur_mask, STREAM_IDX_W'(NUM_STREAMS - 1));
		frames_in_test = 0;
		grants_in_test = 0;
		cfg     <= '{want_at: cur_want_at, stream_mask: cur_mask, slot_len: cur_slot};
		at_byte <= test_mem[base + 3][7:0];
		streams <= fill;
		@(posedge clock);
		sending <= 1'b1;
		repeat (hold)
			@(posedge clock);
		sending <= 1'b0;
		repeat (2)
			@(posedge clock);
		while (quiet_cycles < QUIET_NEED)
			@(posedge clock); // slice and frame in flight still finish.
		if (!cur_want_at && cur_mask == '0 && frames_in_test != 0)
		begin
			$display("test %0d sent frames although no stream was enabled.", t);
			error_count++;
		end
		else if ((cur_want_at || cur_mask != '0) && frames_in_test == 0)
		begin
			$display("test %0d received no frame.", t);
			error_count++;
		end
		if (!cur_want_at && cur_mask != '0 && grants_in_test == 0)
		begin
			$display("test %0d granted no stream.", t);
			error_count++;
		end
	endtask

	initial
	begin
		resetn       = 1'b0;
		sending      = 1'b0;
		cfg          = '0;
		streams      = '0;
		at_byte      = '0;
		cur_want_at  = 1'b0;
		cur_mask     = '0;
		cur_slot     = '0;
		expect_idx   = '0;
		prev_sel     = '0;
		prev_sending = 1'b0;
		sel_hist[0]  = '0;
		sel_hist[1]  = '0;
		sel_hist[2]  = '0;
		rx_active    = 1'b0;
		rx_expect_ok = 1'b0;
		rx_count     = 0;
		rx_data      = '0;
		rx_expect    = '0;
		grant_len    = 0;
		quiet_cycles = 0;
		cycle_count  = 0;
		cycle_limit  = 0;
		error_count  = 0;
		frame_count  = 0;
		grant_count  = 0;
		void'($urandom(90993));
		for (int i = 0; i < MAX_TESTS * FIELDS; i++)
			test_mem[i] = '0;
		$readmemh("verification/stream_switch_tests.txt", test_mem);
		num_tests = 0;
		run_total = 0;
		while (num_tests < MAX_TESTS && test_mem[num_tests * FIELDS + 5] != '0)
		begin
			run_total += int'(test_mem[num_tests * FIELDS + 5]);
			num_tests++;
		end
		if (num_tests == 0)
		begin
			$display("no test vectors were read.");
			error_count++;
		end
		cycle_limit = run_total + 200;
		repeat (4)
			@(posedge clock);
		resetn <= 1'b1;
		repeat (4)
		begin
			@(negedge clock); // line and selection must rest before sending rises.
			if (select.valid !== 1'b0)
			begin
				$display("FAIL select_o.valid: expected 0 got %h", select.valid);
				error_count++;
			end
			if (tx !== 1'b1)
			begin
				$display("FAIL tx_o: expected 1 got %h", tx);
				error_count++;
			end
		end
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		assert_count = int'(i_stream_switch_top.i_stream_scheduler.i_sched_checker.failures)
			+ int'(i_stream_switch_top.i_frame_loader.i_loader_checker.failures);
		$display("tests %0d, grants %0d, frames %0d, check errors %0d, assertion errors %0d",
			num_tests, grant_count, frame_count, error_count, assert_count);
		if (error_count == 0 && assert_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/stream_switch_pkg.sv
logic/stream_scheduler.sv
logic/frame_loader.sv
logic/uart_tx.sv
logic/stream_switch_top.sv
verification/stream_switch_checker.sv
verification/tb_stream_switch.sv

// ==== Makefile ====
# Verilator build and run of the stream switch testbench.
# Every variable below can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= tb_stream_switch
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= -Wall
RUN_FLAGS  ?= +verilator+error+limit+1000

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/stream_switch_tests.txt ====
// stream switch test vectors, one test per line, all fields in hex.
// want_at  mask  slot_len  at_byte  data  run_len
// data 00 takes the stream bytes from the random generator, other values give a fixed pattern.
// run_len is the length of a whole test in cycles, the last 80 are kept for the final frame.
0 FF 004 00 00 0C8
0 A5 00A 00 3C 12C
0 80 002 00 00 0C8
0 11 000 00 5A 0C8
1 00 000 41 00 0C8
0 00 008 00 00 0C8
0 0E 00F 00 00 190
1 FF 003 0D 77 0C8
0 01 001 00 C3 0C8
0 C0 006 00 00 0FA
0 42 005 00 96 12C
1 3C 007 2B 00 0A0
0 FF 000 00 E1 0DC
